// ==== Makefile ====
SIM     ?= verilator
FLAGS   ?= --binary --timing --assert
TOP     ?= mm_tb
FLIST   ?= vlog.f
OBJ_DIR ?= obj_dir
LOG     ?= sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "RESULT: FAIL" >> $(LOG)
	@cat $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/axi_mem_model.sv ====
/*
 * AXI slave memory model: 1024 words, INCR bursts, optional random ready
 * stalls and random interleaving of the two read IDs
 */
`timescale 1ns/1ns

module axi_mem_model (
    input  logic            clk,
    input  logic            stall_en_i,
    input  mm_pkg::axi_ar_t ar_i,
    output logic            arready_o,
    output mm_pkg::axi_r_t  r_o,
    input  logic            rready_i,
    input  mm_pkg::axi_aw_t aw_i,
    output logic            awready_o,
    input  mm_pkg::axi_w_t  w_i,
    output logic            wready_o,
    output mm_pkg::axi_b_t  b_o,
    input  logic            bready_i
);
    logic [31:0]     mem [1024];
    integer          seed;
    logic [9:0]      rd_ptr [2];
    int              rd_left [2];
    logic [9:0]      wr_ptr;
    logic            r_sel;
    logic            ar_fire;
    logic            r_fire;
    logic            aw_fire;
    logic            w_fire;
    logic            b_fire;
    mm_pkg::axi_ar_t ar_q;
    mm_pkg::axi_aw_t aw_q;
    mm_pkg::axi_w_t  w_q;

    function automatic logic stall();
        return stall_en_i && (($random(seed) & 3) == 0);
    endfunction

    initial begin
        seed = 32'h41d4_d729;
        // background pattern, a function of every address bit
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'hC0DE_0000 ^ (i * 32'h9E37_79B9);
        rd_left[0] = 0;
        rd_left[1] = 0;
        rd_ptr[0]  = '0;
        rd_ptr[1]  = '0;
        wr_ptr     = '0;
        r_sel      = 1'b0;
        {ar_fire, r_fire, aw_fire, w_fire, b_fire} = '0;
        arready_o = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        r_o       = '0;
        b_o       = '0;
    end

    // handshakes seen on the rising edge
    always @(posedge clk) begin
        ar_fire <= ar_i.valid && arready_o;
        r_fire  <= r_o.valid && rready_i;
        aw_fire <= aw_i.valid && awready_o;
        w_fire  <= w_i.valid && wready_o;
        b_fire  <= b_o.valid && bready_i;
        ar_q    <= ar_i;
        aw_q    <= aw_i;
        w_q     <= w_i;
    end

    // new responses go out on the falling edge
    always @(negedge clk) begin
        if (ar_fire) begin
            rd_ptr[ar_q.id[0]]  = ar_q.addr[11:2];
            rd_left[ar_q.id[0]] = int'(ar_q.len) + 1;
        end
        if (r_fire) begin
            rd_ptr[r_sel]  = rd_ptr[r_sel] + 10'd1;
            rd_left[r_sel] = rd_left[r_sel] - 1;
            r_o.valid      = 1'b0;
        end
        if (aw_fire)
            wr_ptr = aw_q.addr[11:2];
        if (b_fire)
            b_o = '0;
        if (w_fire) begin
            mem[wr_ptr] = w_q.data;
            wr_ptr      = wr_ptr + 10'd1;
            if (w_q.last)
                b_o.valid = 1'b1;
        end
        arready_o = !stall();
        awready_o = !stall();
        wready_o  = !stall();
        if (!r_o.valid && (rd_left[0] > 0 || rd_left[1] > 0) && !stall()) begin
            if (rd_left[0] > 0 && rd_left[1] > 0)
                r_sel = stall_en_i ? 1'($random(seed)) : 1'b0;
            else
                r_sel = (rd_left[0] == 0);
            r_o.valid = 1'b1;
            r_o.id    = {3'b000, r_sel};
            r_o.data  = mem[rd_ptr[r_sel]];
            r_o.last  = (rd_left[r_sel] == 1);
        end
    end

endmodule

// ==== tests/mm_assertions.sv ====
/*
 * protocol and timing checks for the matrix-multiply accelerator top
 */
`timescale 1ns/1ns

module mm_assertions (
    input logic            clk,
    input logic            rst_n,
    input mm_pkg::axi_ar_t ar_i,
    input logic            arready_i,
    input mm_pkg::axi_aw_t aw_i,
    input logic            awready_i,
    input mm_pkg::axi_w_t  w_i,
    input logic            wready_i,
    input logic            rready_i,
    input logic            bready_i,
    input logic            mm_start_i,
    input logic            mm_done_i,
    input logic            a_full_i,
    input logic            b_full_i,
    input logic            done_i
);
    int         fail_cnt = 0;
    logic [3:0] w_beat;

    always @(posedge clk) begin
        if (!rst_n)
            w_beat <= 4'd0;
        else if (w_i.valid && wready_i)
            w_beat <= w_beat + 4'd1;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_i.valid && !arready_i |=> ar_i.valid && $stable(ar_i))
        else begin fail_cnt++; $error("read address changed before arready"); end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_i.valid && !awready_i |=> aw_i.valid && $stable(aw_i))
        else begin fail_cnt++; $error("write address changed before awready"); end

    // 16-beat INCR bursts of full 32-bit words
    axi_fmt: assert property (@(posedge clk) disable iff (!rst_n)
        (!ar_i.valid || (ar_i.len == 8'd15 && ar_i.size == 3'd2 && ar_i.burst == 2'b01))
            && (!aw_i.valid || (aw_i.len == 8'd15 && aw_i.size == 3'd2
            && aw_i.burst == 2'b01))
            && (!w_i.valid || w_i.strb == 4'hf))
        else begin fail_cnt++; $error("burst is not a 16-beat INCR of full words"); end

    wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
        w_i.valid && wready_i |-> (w_i.last == (w_beat == 4'd15)))
        else begin fail_cnt++; $error("wlast not on the sixteenth beat"); end

    mm_lat: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_i |-> ##5 mm_done_i)
        else begin fail_cnt++; $error("multiply done not 5 cycles after start"); end

    mm_early: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i |-> $past(mm_start_i, 5))
        else begin fail_cnt++; $error("multiply done without a start 5 cycles before"); end

    done_one: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else begin fail_cnt++; $error("done pulse longer than one cycle"); end

    reset_low: assert property (@(posedge clk)
        $rose(rst_n) |-> !ar_i.valid && !aw_i.valid && !w_i.valid && !rready_i
            && !bready_i && !mm_start_i && !done_i && !a_full_i && !b_full_i)
        else begin fail_cnt++; $error("control output high after reset"); end

endmodule

bind mm_top mm_assertions chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar_o),
    .arready_i  (arready_i),
    .aw_i       (aw_o),
    .awready_i  (awready_i),
    .w_i        (w_o),
    .wready_i   (wready_i),
    .rready_i   (rready_o),
    .bready_i   (bready_o),
    .mm_start_i (mm_start),
    .mm_done_i  (mm_done),
    .a_full_i   (a_full),
    .b_full_i   (b_full),
    .done_i     (done_o)
);

// ==== tests/mm_tb.sv ====
/*
 * testbench for the matrix-multiply accelerator: loads A and B, runs the
 * DUT and compares C against a golden product modulo 2^32
 */
`timescale 1ns/1ns

module mm_tb;
    localparam int MAX_CYCLES = 4000;
    localparam int MEM_WORDS  = 1024;

    logic            clk;
    logic            rst_n;
    logic [31:0]     a_addr;
    logic [31:0]     b_addr;
    logic [31:0]     c_addr;
    logic            start;
    logic            done;
    logic            stall_en;
    mm_pkg::axi_ar_t ar;
    logic            arready;
    mm_pkg::axi_r_t  r;
    logic            rready;
    mm_pkg::axi_aw_t aw;
    logic            awready;
    mm_pkg::axi_w_t  w;
    logic            wready;
    mm_pkg::axi_b_t  b;
    logic            bready;

    integer        seed;
    int            errors;
    int            test_errs;
    int            tests_run;
    int            tests_failed;
    int            done_cnt;
    int            aw_cnt;
    logic [31:0]   snap [MEM_WORDS];
    mm_pkg::elem_t gold [16];

    tb_clock clk0 (.clk(clk), .rst_n(rst_n));

    mm_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(a_addr), .mat_b_addr_i(b_addr), .mat_c_addr_i(c_addr),
        .start_i(start), .done_o(done),
        .ar_o(ar), .arready_i(arready), .r_i(r), .rready_o(rready),
        .aw_o(aw), .awready_i(awready), .w_o(w), .wready_i(wready),
        .b_i(b), .bready_o(bready)
    );

    axi_mem_model mem0 (
        .clk(clk), .stall_en_i(stall_en),
        .ar_i(ar), .arready_o(arready), .r_o(r), .rready_i(rready),
        .aw_i(aw), .awready_o(awready), .w_i(w), .wready_o(wready),
        .b_o(b), .bready_i(bready)
    );

    // done pulses and write bursts seen per run
    always @(posedge clk) begin
        if (done)
            done_cnt++;
        if (aw.valid && awready)
            aw_cnt++;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // mode 0 is identity A and counting B, mode 1 is random
    task automatic load_mats(input int a, input int bw, input int mode);
        for (int idx = 0; idx < 16; idx++) begin
            mem0.mem[a + idx]  = (mode == 0) ? 32'((idx % 5) == 0) : $random(seed);
            mem0.mem[bw + idx] = (mode == 0) ? 32'(idx + 1) : $random(seed);
        end
    endtask

    // A column-major, B row-major, C row-major
    task automatic calc_golden(input int a, input int bw);
        mm_pkg::elem_t sum;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                sum = '0;
                for (int k = 0; k < 4; k++)
                    sum = sum + mem0.mem[a + k * 4 + i] * mem0.mem[bw + k * 4 + j];
                gold[i * 4 + j] = sum;
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_test(input string name, input int a, input int bw, input int c,
                            input int mode, input bit stalls, input bit restart);
        int d0;
        int w0;
        test_errs = 0;
        load_mats(a, bw, mode);
        calc_golden(a, bw);
        for (int i = 0; i < MEM_WORDS; i++)
            snap[i] = mem0.mem[i];
        stall_en = stalls;
        a_addr   = 32'(a * 4);
        b_addr   = 32'(bw * 4);
        c_addr   = 32'(c * 4);
        d0 = done_cnt;
        w0 = aw_cnt;
        pulse_start();
        if (restart) begin
            repeat (6) @(negedge clk);
            pulse_start();
        end
        while (done_cnt == d0)
            @(negedge clk);
        // quiet period to catch a stray second run
        repeat (20) @(negedge clk);
        if (done_cnt - d0 != 1) begin
            $display("%s: %0d done pulses for one accepted start", name, done_cnt - d0);
            test_errs++;
        end
        if (aw_cnt - w0 != 1) begin
            $display("%s: %0d write bursts for one accepted start", name, aw_cnt - w0);
            test_errs++;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i >= c && i < c + 16) begin
                if (mem0.mem[i] !== gold[i - c]) begin
                    $display("ERR %s C[%0d][%0d]: expected %h actual %h", name,
                             (i - c) / 4, (i - c) % 4, gold[i - c], mem0.mem[i]);
                    test_errs++;
                end
            end else if (mem0.mem[i] !== snap[i]) begin
                $display("%s: word at 0x%h changed outside the C region", name, i * 4);
                test_errs++;
            end
        end
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        errors += test_errs;
        $display("test %s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
    endtask

    initial begin
        seed         = 32'h41d4_d729;
        start        = 1'b0;
        stall_en     = 1'b0;
        a_addr       = '0;
        b_addr       = '0;
        c_addr       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_cnt     = 0;
        aw_cnt       = 0;
        wait (rst_n);
        repeat (2) @(negedge clk);

        run_test("identity", 0, 16, 32, 0, 1'b0, 1'b0);
        run_test("random_stall", 64, 80, 96, 1, 1'b1, 1'b0);
        run_test("back_to_back_0", 128, 144, 160, 1, 1'b0, 1'b0);
        run_test("back_to_back_1", 200, 216, 240, 1, 1'b1, 1'b0);
        run_test("back_to_back_2", 300, 320, 340, 1, 1'b1, 1'b0);
        run_test("restart_ignored", 400, 416, 432, 1, 1'b1, 1'b1);

        errors += dut0.chk0.fail_cnt;
        $display("tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut0.chk0.fail_cnt);
        if (errors == 0 && tests_failed == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
/*
 * clock and reset source for the testbench, 40 ns period, reset held
 * low for three cycles
 */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // release on a falling edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verilog/dma_engine.sv ====
/*
 * DMA engine: reads A and B as two overlapped AXI bursts, steers beats
 * into the row buffers, starts the multiply and writes C back in one burst
 */
`timescale 1ns/1ns

module dma_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mm_pkg::ADDR_W-1:0] mat_a_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_b_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_c_addr_i,
    input  logic                      start_i,
    output logic                      done_o,
    output mm_pkg::axi_ar_t           ar_o,
    input  logic                      arready_i,
    input  mm_pkg::axi_r_t            r_i,
    output logic                      rready_o,
    output mm_pkg::axi_aw_t           aw_o,
    input  logic                      awready_i,
    output mm_pkg::axi_w_t            w_o,
    input  logic                      wready_i,
    input  mm_pkg::axi_b_t            b_i,
    output logic                      bready_o,
    output logic                      buf_clear_o,
    output logic                      a_beat_valid_o,
    output logic                      b_beat_valid_o,
    output mm_pkg::elem_t             beat_data_o,
    input  logic                      a_full_i,
    input  logic                      b_full_i,
    output logic                      mm_start_o,
    input  logic                      mm_done_i,
    input  mm_pkg::mat_t              result_i
);
    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        WAIT_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } state_t;

    state_t                    state;
    state_t                    state_n;
    logic [mm_pkg::ADDR_W-1:0] a_base;
    logic [mm_pkg::ADDR_W-1:0] b_base;
    logic [mm_pkg::ADDR_W-1:0] c_base;
    logic [3:0]                wr_cnt;
    logic                      accept;
    logic                      r_fire;
    logic                      w_fire;
    logic                      both_full;

    // start is only taken from idle
    assign accept    = (state == IDLE) && start_i;
    assign r_fire    = (state == LOAD) && r_i.valid;
    assign w_fire    = (state == WRITE_C) && wready_i;
    assign both_full = a_full_i && b_full_i;

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_n;
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE:    if (start_i) state_n = ADDR_A;
            ADDR_A:  if (arready_i) state_n = ADDR_B;
            ADDR_B:  if (arready_i) state_n = LOAD;
            LOAD:    if (both_full) state_n = WAIT_MM;
            WAIT_MM: if (mm_done_i) state_n = ADDR_C;
            ADDR_C:  if (awready_i) state_n = WRITE_C;
            WRITE_C: if (w_fire && w_o.last) state_n = WAIT_B;
            WAIT_B:  if (b_i.valid) state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    // base addresses captured once per run
    always_ff @(posedge clk) begin
        if (accept) begin
            a_base <= mat_a_addr_i;
            b_base <= mat_b_addr_i;
            c_base <= mat_c_addr_i;
        end
    end

    // write beat counter, wraps back to 0 after the 16th beat
    always_ff @(posedge clk) begin
        if (!rst_n)
            wr_cnt <= 4'd0;
        else if (w_fire)
            wr_cnt <= wr_cnt + 4'd1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            done_o <= 1'b0;
        else
            done_o <= (state == WAIT_B) && b_i.valid;
    end

    // read address, A burst first then B
    always_comb begin
        ar_o.valid = (state == ADDR_A) || (state == ADDR_B);
        ar_o.id    = (state == ADDR_B) ? mm_pkg::ID_B : mm_pkg::ID_A;
        ar_o.addr  = (state == ADDR_B) ? b_base : a_base;
        ar_o.len   = mm_pkg::AXI_LEN;
        ar_o.size  = mm_pkg::AXI_SIZE_WORD;
        ar_o.burst = mm_pkg::AXI_BURST_INCR;
    end

    // R beats steered by id
    assign rready_o       = (state == LOAD);
    assign a_beat_valid_o = r_fire && (r_i.id == mm_pkg::ID_A);
    assign b_beat_valid_o = r_fire && (r_i.id == mm_pkg::ID_B);
    assign beat_data_o    = r_i.data;

    assign buf_clear_o = accept;
    assign mm_start_o  = (state == LOAD) && both_full;

    always_comb begin
        aw_o.valid = (state == ADDR_C);
        aw_o.addr  = c_base;
        aw_o.len   = mm_pkg::AXI_LEN;
        aw_o.size  = mm_pkg::AXI_SIZE_WORD;
        aw_o.burst = mm_pkg::AXI_BURST_INCR;
    end

    // C goes out row-major, C[0][0] first
    always_comb begin
        w_o.valid = (state == WRITE_C);
        w_o.data  = result_i[wr_cnt[3:2]][wr_cnt[1:0]];
        w_o.strb  = '1;
        w_o.last  = (wr_cnt == 4'(mm_pkg::BEATS - 1));
    end

    assign bready_o = (state == WAIT_B);

endmodule

// ==== verilog/mm_engine.sv ====
/*
 * multiply engine: forms C = A x B as four outer products of buffer A
 * columns and buffer B rows, one per cycle, modulo 2^32
 */
`timescale 1ns/1ns

module mm_engine (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_i,
    output logic [1:0]   row_addr_o,
    input  mm_pkg::row_t a_col_i,
    input  mm_pkg::row_t b_row_i,
    output mm_pkg::mat_t result_o,
    output logic         done_o
);
    mm_pkg::mat_t acc;
    logic [1:0]   issue_cnt;
    logic         issue_act;
    logic         rd_vld;
    logic         rd_last;

    // address 0 goes out in the start cycle itself
    assign row_addr_o = start_i ? 2'd0 : issue_cnt;

    // issue side: one buffer read per cycle, addresses 0..3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_cnt <= 2'd0;
            issue_act <= 1'b0;
            rd_vld    <= 1'b0;
            rd_last   <= 1'b0;
        end else if (start_i) begin
            issue_cnt <= 2'd1;
            issue_act <= 1'b1;
            rd_vld    <= 1'b1;
            rd_last   <= 1'b0;
        end else if (issue_act) begin
            issue_cnt <= issue_cnt + 2'd1;
            issue_act <= (issue_cnt != 2'd3);
            rd_vld    <= 1'b1;
            rd_last   <= (issue_cnt == 2'd3);
        end else begin
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
        end
    end

    // accumulate side, one cycle behind the issue
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc <= '0;
        end else if (rd_vld) begin
            for (int i = 0; i < mm_pkg::MAT_N; i++) begin
                for (int j = 0; j < mm_pkg::MAT_N; j++) begin
                    // C[i][j] += A[i][k] * B[k][j], truncated to 32 bits
                    acc[i][j] <= acc[i][j] + a_col_i[i] * b_row_i[j];
                end
            end
        end
    end

    // done lands with the last accumulate, 5 cycles after start
    always_ff @(posedge clk) begin
        if (!rst_n)
            done_o <= 1'b0;
        else
            done_o <= rd_vld && rd_last && !start_i;
    end

    // accumulators hold until the next start
    assign result_o = acc;

endmodule

// ==== verilog/mm_pkg.sv ====
/*
 * mm_pkg: sizes, row and matrix types and AXI channel structs shared
 * by the matrix-multiply accelerator
 */
package mm_pkg;

    // matrix geometry
    localparam int MAT_N  = 4;
    localparam int ELEM_W = 32;
    localparam int ROW_W  = MAT_N * ELEM_W;
    localparam int BEATS  = MAT_N * MAT_N;

    // AXI field widths and fixed encodings
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam logic [ID_W-1:0] ID_A = 4'd0;
    localparam logic [ID_W-1:0] ID_B = 4'd1;
    localparam logic [7:0] AXI_LEN        = 8'(BEATS - 1);
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef elem_t [MAT_N-1:0] row_t;
    typedef row_t [MAT_N-1:0]  mat_t;

    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
        elem_t           data;
        logic            last;
    } axi_r_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic              valid;
        elem_t             data;
        logic [ELEM_W/8-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

endpackage

// ==== verilog/mm_top.sv ====
/*
 * matrix-multiply accelerator top: DMA engine, two row buffers and the
 * multiply engine behind one AXI master port
 */
`timescale 1ns/1ns

module mm_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mm_pkg::ADDR_W-1:0] mat_a_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_b_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_c_addr_i,
    input  logic                      start_i,
    output logic                      done_o,
    output mm_pkg::axi_ar_t           ar_o,
    input  logic                      arready_i,
    input  mm_pkg::axi_r_t            r_i,
    output logic                      rready_o,
    output mm_pkg::axi_aw_t           aw_o,
    input  logic                      awready_i,
    output mm_pkg::axi_w_t            w_o,
    input  logic                      wready_i,
    input  mm_pkg::axi_b_t            b_i,
    output logic                      bready_o
);
    logic          buf_clear;
    logic          a_beat_valid;
    logic          b_beat_valid;
    mm_pkg::elem_t beat_data;
    logic          a_full;
    logic          b_full;
    logic          mm_start;
    logic          mm_done;
    mm_pkg::mat_t  result;
    logic [1:0]    row_addr;
    mm_pkg::row_t  a_col;
    mm_pkg::row_t  b_row;

    dma_engine dma0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .mat_a_addr_i   (mat_a_addr_i),
        .mat_b_addr_i   (mat_b_addr_i),
        .mat_c_addr_i   (mat_c_addr_i),
        .start_i        (start_i),
        .done_o         (done_o),
        .ar_o           (ar_o),
        .arready_i      (arready_i),
        .r_i            (r_i),
        .rready_o       (rready_o),
        .aw_o           (aw_o),
        .awready_i      (awready_i),
        .w_o            (w_o),
        .wready_i       (wready_i),
        .b_i            (b_i),
        .bready_o       (bready_o),
        .buf_clear_o    (buf_clear),
        .a_beat_valid_o (a_beat_valid),
        .b_beat_valid_o (b_beat_valid),
        .beat_data_o    (beat_data),
        .a_full_i       (a_full),
        .b_full_i       (b_full),
        .mm_start_o     (mm_start),
        .mm_done_i      (mm_done),
        .result_i       (result)
    );

    // buffer A holds columns of A
    row_buffer buf_a0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (buf_clear),
        .beat_valid_i (a_beat_valid),
        .beat_data_i  (beat_data),
        .rd_addr_i    (row_addr),
        .rd_row_o     (a_col),
        .full_o       (a_full)
    );

    // buffer B holds rows of B
    row_buffer buf_b0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (buf_clear),
        .beat_valid_i (b_beat_valid),
        .beat_data_i  (beat_data),
        .rd_addr_i    (row_addr),
        .rd_row_o     (b_row),
        .full_o       (b_full)
    );

    mm_engine mm0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (mm_start),
        .row_addr_o (row_addr),
        .a_col_i    (a_col),
        .b_row_i    (b_row),
        .result_o   (result),
        .done_o     (mm_done)
    );

endmodule

// ==== verilog/row_buffer.sv ====
/*
 * row buffer: packs 32-bit read beats into 128-bit rows, keeps four rows
 * and returns one row per cycle through a registered read port
 */
`timescale 1ns/1ns

module row_buffer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear_i,
    input  logic          beat_valid_i,
    input  mm_pkg::elem_t beat_data_i,
    input  logic [1:0]    rd_addr_i,
    output mm_pkg::row_t  rd_row_o,
    output logic          full_o
);
    logic [mm_pkg::ROW_W-1:0] mem [mm_pkg::MAT_N];
    mm_pkg::elem_t [2:0]      partial;
    logic [1:0]               beat_cnt;
    logic [1:0]               row_ptr;
    logic                     wr_en;

    // beats after the fourth row are dropped
    assign wr_en = beat_valid_i && !full_o;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            beat_cnt <= 2'd0;
            row_ptr  <= 2'd0;
            full_o   <= 1'b0;
        end else if (wr_en) begin
            beat_cnt <= beat_cnt + 2'd1;
            if (beat_cnt == 2'd3) begin
                row_ptr <= row_ptr + 2'd1;
                if (row_ptr == 2'd3)
                    full_o <= 1'b1;
            end
        end
    end

    // element 0 of a row is the first beat
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (beat_cnt == 2'd3)
                mem[row_ptr] <= {beat_data_i, partial[2], partial[1], partial[0]};
            else
                partial[beat_cnt] <= beat_data_i;
        end
        rd_row_o <= mem[rd_addr_i];
    end

endmodule

// ==== vlog.f ====
verilog/mm_pkg.sv
verilog/row_buffer.sv
verilog/mm_engine.sv
verilog/dma_engine.sv
verilog/mm_top.sv
tests/tb_clock.sv
tests/axi_mem_model.sv
tests/mm_assertions.sv
tests/mm_tb.sv
